/* ex_mem_path.f */
source/ex_mem_pkg.sv
source/alu.sv
source/execution_registers.sv
source/data_memory_stage.sv
source/ex_mem_path.sv
tests/tb_ex_mem_path.sv

/* Bender.yml */
package:
  name: ex_mem_path

sources:
  # Design, package first
  - source/ex_mem_pkg.sv
  - source/alu.sv
  - source/execution_registers.sv
  - source/data_memory_stage.sv
  - source/ex_mem_path.sv

  # Testbench
  - target: test
    files:
      - tests/tb_ex_mem_path.sv

/* tests/tb_ex_mem_path.sv */
`timescale 1ns/1ps

module tb_ex_mem_path;
  import ex_mem_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam int MEM_LATENCY = 3;
  // About 1000 cycles of tests with memory ops near 7 cycles each
  // Four times that as margin
  localparam int TIMEOUT_CYCLES = 4000;
  // Random test works inside words 128 to 143
  localparam word_t RAND_BASE = 32'h0000_0200;

  logic   clk;
  logic   rst_n;
  logic   issue_valid;
  issue_t issue;
  logic   stall;
  logic   issue_blocked;
  logic   wb_valid;
  wb_t    wb;

  // Reference memory and write-backs still owed by the DUT
  word_t exp_mem [MEM_WORDS];
  wb_t   exp_q [$];
  int    errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  int    cycle_count = 0;

  ex_mem_path #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_ex_mem_path (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid   (issue_valid),
    .issue         (issue),
    .stall         (stall),
    .issue_blocked (issue_blocked),
    .wb_valid      (wb_valid),
    .wb            (wb)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // ALU rules with signed slt and shifts by the low five bits
  function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      default: return '0;
    endcase
  endfunction

  // Pattern for fresh memory words where every address bit matters
  function automatic word_t fill_word(word_t addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A5A_5A5A;
  endfunction

  function automatic issue_t make_alu(alu_op_t op, reg_idx_t rd, word_t a, word_t b,
                                      logic use_imm);
    issue_t t;
    t = '0;
    t.instruction      = 32'h0000_0013;
    t.ctrl.alu_op      = op;
    t.ctrl.alu_src_imm = use_imm;
    t.ctrl.reg_write   = 1'b1;
    t.rd               = rd;
    t.rs1_value        = a;
    // Unused operand carries junk so the select is exercised
    t.rs2_value        = use_imm ? ~b : b;
    t.ext_imm          = use_imm ? b : ~b;
    return t;
  endfunction

  function automatic issue_t make_load(reg_idx_t rd, word_t base, word_t off, logic is_byte);
    issue_t t;
    t = make_alu(ALU_ADD, rd, base, off, 1'b1);
    t.instruction         = 32'h0000_0003;
    t.ctrl.mem_to_reg     = 1'b1;
    t.ctrl.d_cache_access = 1'b1;
    t.ctrl.is_byte_op     = is_byte;
    return t;
  endfunction

  // Write enable stays set so the memory stage has to drop it for a store
  function automatic issue_t make_store(word_t base, word_t off, word_t data, logic is_byte);
    issue_t t;
    t = make_alu(ALU_ADD, 5'd0, base, off, 1'b1);
    t.instruction         = 32'h0000_0023;
    t.ctrl.d_cache_access = 1'b1;
    t.ctrl.d_cache_op     = 1'b1;
    t.ctrl.is_byte_op     = is_byte;
    t.rs2_value           = data;
    return t;
  endfunction

  // Expected write-back of one operation with the memory model updated in issue order
  task automatic predict(input issue_t op, output wb_t exp);
    word_t      addr;
    logic [7:0] idx;
    logic [1:0] sel;
    addr = model_alu(op.ctrl.alu_op, op.rs1_value,
                     op.ctrl.alu_src_imm ? op.ext_imm : op.rs2_value);
    idx  = addr[9:2];
    sel  = addr[1:0];
    exp.rd        = op.rd;
    exp.data      = addr;
    exp.reg_write = op.ctrl.reg_write;
    if (op.ctrl.d_cache_access && op.ctrl.d_cache_op)
    begin
      // Stores never write a register
      exp.reg_write = 1'b0;
      if (op.ctrl.is_byte_op)
        exp_mem[idx][8*sel +: 8] = op.rs2_value[7:0];
      else
        exp_mem[idx] = op.rs2_value;
    end
    else if (op.ctrl.d_cache_access)
    begin
      exp.data = op.ctrl.is_byte_op ? {24'b0, exp_mem[idx][8*sel +: 8]} : exp_mem[idx];
    end
  endtask

  // Drive one operation once the port is free and retry if it turns blocked
  task automatic issue_op(input issue_t op);
    wb_t  exp;
    logic taken;
    taken = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      if (!issue_blocked)
      begin
        @(posedge clk);
        issue_valid <= 1'b1;
        issue       <= op;
        @(negedge clk);
        // Level here is the one the accept edge sees
        taken = !issue_blocked;
        if (taken)
        begin
          predict(op, exp);
          exp_q.push_back(exp);
        end
        @(posedge clk);
        issue_valid <= 1'b0;
      end
    end
  endtask

  // Stall held for n cycles while nothing may come out
  task automatic hold_stall(input int n);
    @(posedge clk);
    stall <= 1'b1;
    repeat (n)
    begin
      @(negedge clk);
      check_value(wb_valid, 1'b0, "wb_valid during stall");
      check_value(issue_blocked, 1'b1, "issue_blocked during stall");
    end
    @(posedge clk);
    stall <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("At %0t ns, %0d write-backs never arrived", $time, exp_q.size());
      exp_q.delete();
    end
    // Quiet cycles expose duplicated write-backs
    repeat (3) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    $display("Test %-16s done, %0d errors", name, errors - err_start);
  endtask

  // Every write-back against the oldest owed one
  always @(negedge clk)
  begin
    if (rst_n && wb_valid)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("At %0t ns a write-back arrived with no operation pending", $time);
      end
      else
      begin
        check_value(wb.rd, exp_q[0].rd, "write-back rd");
        check_value(wb.reg_write, exp_q[0].reg_write, "write-back reg_write");
        if (exp_q[0].reg_write)
          check_value(wb.data, exp_q[0].data, "write-back data");
        void'(exp_q.pop_front());
      end
    end
  end

  task automatic reset_test();
    int err_start;
    err_start = errors;
    repeat (8)
    begin
      @(negedge clk);
      check_value(wb_valid, 1'b0, "wb_valid after reset");
      check_value(issue_blocked, 1'b0, "issue_blocked after reset");
    end
    report_test("reset", err_start);
  endtask

  task automatic alu_test();
    int      err_start;
    alu_op_t op;
    word_t   a;
    word_t   b;
    err_start = errors;
    for (int i = 0; i < 8; i++)
    begin
      op = alu_op_t'(i);
      a  = $urandom();
      b  = $urandom();
      issue_op(make_alu(op, reg_idx_t'(i + 1), a, b, 1'b0));
      issue_op(make_alu(op, reg_idx_t'(i + 9), a, b, 1'b1));
    end
    // Signed compare corners and a zero result
    issue_op(make_alu(ALU_SLT, 5'd20, 32'hFFFF_FFF0, 32'h0000_0004, 1'b0));
    issue_op(make_alu(ALU_SLT, 5'd21, 32'h0000_0004, 32'hFFFF_FFF0, 1'b1));
    issue_op(make_alu(ALU_SUB, 5'd22, 32'd7, 32'd7, 1'b1));
    wait_drain();
    report_test("alu", err_start);
  endtask

  task automatic memory_test();
    int err_start;
    err_start = errors;
    issue_op(make_store(32'h100, 32'h0, 32'hDEAD_BEEF, 1'b0));
    issue_op(make_load(5'd3, 32'h100, 32'h0, 1'b0));
    issue_op(make_store(32'h100, 32'h4, 32'h1122_3344, 1'b0));
    issue_op(make_store(32'h100, 32'h5, 32'h0000_00AB, 1'b1));
    issue_op(make_load(5'd4, 32'h100, 32'h5, 1'b1));
    issue_op(make_store(32'h100, 32'h7, 32'hFFFF_FFCD, 1'b1));
    // Only bytes 1 and 3 changed
    issue_op(make_load(5'd5, 32'h100, 32'h4, 1'b0));
    wait_drain();
    report_test("memory", err_start);
  endtask

  task automatic blocking_test();
    int err_start;
    int n;
    err_start = errors;
    n = 0;
    issue_op(make_store(32'h180, 32'h0, 32'hA5A5_0F0F, 1'b0));
    @(negedge clk);
    while (!wb_valid && n < 50)
    begin
      check_value(issue_blocked, 1'b1, "issue_blocked during access");
      n++;
      @(negedge clk);
    end
    check_value(wb_valid, 1'b1, "store write-back");
    check_value(wb.reg_write, 1'b0, "store reg_write");
    check_value(issue_blocked, 1'b1, "issue_blocked at write-back");
    @(negedge clk);
    check_value(issue_blocked, 1'b0, "issue_blocked after write-back");
    issue_op(make_load(5'd7, 32'h180, 32'h0, 1'b0));
    issue_op(make_alu(ALU_ADD, 5'd8, 32'd40, 32'd2, 1'b1));
    issue_op(make_alu(ALU_XOR, 5'd9, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 1'b0));
    wait_drain();
    report_test("blocking", err_start);
  endtask

  task automatic stall_test();
    int err_start;
    err_start = errors;
    // Write-back already pending when the stall hits
    issue_op(make_alu(ALU_ADD, 5'd1, 32'd100, 32'd23, 1'b1));
    hold_stall(5);
    issue_op(make_store(32'h300, 32'h0, 32'hCAFE_F00D, 1'b0));
    @(posedge clk);
    // Stall in the middle of the access
    hold_stall(6);
    issue_op(make_load(5'd2, 32'h300, 32'h0, 1'b0));
    issue_op(make_alu(ALU_OR, 5'd3, 32'h0000_FF00, 32'h00FF_0000, 1'b0));
    hold_stall(3);
    issue_op(make_alu(ALU_SLL, 5'd4, 32'h0000_0001, 32'd31, 1'b1));
    wait_drain();
    report_test("stall", err_start);
  endtask

  task automatic random_test();
    int       err_start;
    int       kind;
    logic     byte_op;
    word_t    off;
    word_t    a;
    word_t    b;
    reg_idx_t rd;
    alu_op_t  op;
    err_start = errors;
    // Known contents before any load
    for (int i = 0; i < 16; i++)
      issue_op(make_store(RAND_BASE, 4 * i, fill_word(RAND_BASE + 4 * i), 1'b0));
    for (int i = 0; i < 60; i++)
    begin
      kind    = $urandom_range(2, 0);
      byte_op = $urandom_range(1, 0);
      off     = byte_op ? $urandom_range(63, 0) : 4 * $urandom_range(15, 0);
      a       = $urandom();
      b       = $urandom();
      rd      = reg_idx_t'($urandom_range(31, 1));
      op      = alu_op_t'($urandom_range(7, 0));
      case (kind)
        0: issue_op(make_alu(op, rd, a, b, byte_op));
        1: issue_op(make_load(rd, RAND_BASE, off, byte_op));
        default: issue_op(make_store(RAND_BASE, off, b, byte_op));
      endcase
    end
    wait_drain();
    report_test("random", err_start);
  endtask

  // Run limit
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(87));
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue       = '0;
    stall       = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_test();
    alu_test();
    memory_test();
    blocking_test();
    stall_test();
    random_test();
    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* source/ex_mem_path.sv */
`timescale 1ns/1ps

module ex_mem_path #(
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 3
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               issue_valid,
  input  ex_mem_pkg::issue_t issue,
  input  logic               stall,
  output logic               issue_blocked,
  output logic               wb_valid,
  output ex_mem_pkg::wb_t    wb
);
  import ex_mem_pkg::*;

  // ALU to execute register
  word_t   alu_result;
  logic    alu_zero;
  // Execute register to memory stage
  ex_mem_t ex_q;
  logic    active_out;
  logic    locked;
  // Memory stage back to execute register
  logic    unlock;

  // Result computed straight from the issue port
  alu u_alu (
    .ex_ctrl   (issue.ctrl),
    .rs1_value (issue.rs1_value),
    .rs2_value (issue.rs2_value),
    .ext_imm   (issue.ext_imm),
    .result    (alu_result),
    .zero      (alu_zero)
  );

  execution_registers u_execution_registers (
    .clk        (clk),
    .rst_n      (rst_n),
    .active     (issue_valid),
    .stall      (stall),
    .unlock     (unlock),
    .issue      (issue),
    .alu_result (alu_result),
    .alu_zero   (alu_zero),
    .ex_q       (ex_q),
    .active_out (active_out),
    .locked     (locked)
  );

  // Issue waits for a memory access or an external stall
  assign issue_blocked = locked || stall;

  data_memory_stage #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_data_memory_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .active   (active_out),
    .ex_q     (ex_q),
    .unlock   (unlock),
    .wb_valid (wb_valid),
    .wb       (wb)
  );

endmodule

/* source/data_memory_stage.sv */
`timescale 1ns/1ps

module data_memory_stage #(
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 3
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                stall,
  input  logic                active,
  input  ex_mem_pkg::ex_mem_t ex_q,
  output logic                unlock,
  output logic                wb_valid,
  output ex_mem_pkg::wb_t     wb
);
  import ex_mem_pkg::*;

  // Word index width into the array
  localparam int ADDR_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  // Access countdown width
  localparam int CNT_W  = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  word_t             mem [MEM_WORDS];
  mem_state_t        state;
  logic [CNT_W-1:0]  count;
  logic [ADDR_W-1:0] word_addr;
  logic [1:0]        byte_sel;
  word_t             rd_word;
  word_t             store_word;
  word_t             load_data;
  // Last access cycle
  logic              access_done;
  // Registered pulses, shown only outside a stall
  logic              unlock_q;
  logic              wb_valid_q;

  // Byte address from the ALU, low bits pick the byte
  assign word_addr = ex_q.alu_result[ADDR_W+1:2];
  assign byte_sel  = ex_q.alu_result[1:0];
  assign rd_word   = mem[word_addr];

  // Byte stores merge into the old word
  always_comb
  begin
    store_word = rd_word;
    if (ex_q.ctrl.is_byte_op)
      store_word[8*byte_sel +: 8] = ex_q.second_input[7:0];
    else
      store_word = ex_q.second_input;
  end

  // Byte loads are zero-extended
  assign load_data = ex_q.ctrl.is_byte_op ? {24'b0, rd_word[8*byte_sel +: 8]} : rd_word;

  assign access_done = (state == MEM_ACCESS) && (count == '0);

  // Store lands on the last access cycle
  always_ff @(posedge clk)
  begin
    if (rst_n && !stall && access_done && ex_q.ctrl.d_cache_op)
    begin
      mem[word_addr] <= store_word;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= MEM_IDLE;
      count      <= '0;
      unlock_q   <= 1'b0;
      wb_valid_q <= 1'b0;
      wb         <= '0;
    end
    else if (!stall)
    begin
      unlock_q   <= 1'b0;
      wb_valid_q <= 1'b0;
      case (state)
        MEM_IDLE:
        begin
          // Execute register holds ex_q while locked
          if (active && ex_q.ctrl.d_cache_access)
          begin
            state <= MEM_ACCESS;
            count <= CNT_W'(MEM_LATENCY - 1);
          end
          // ALU result straight through in one cycle
          else if (active)
          begin
            wb_valid_q   <= 1'b1;
            wb.rd        <= ex_q.rd;
            wb.data      <= ex_q.alu_result;
            wb.reg_write <= ex_q.ctrl.reg_write;
          end
        end
        MEM_ACCESS:
        begin
          if (count == '0)
          begin
            // Unlock and write-back on the same edge
            state        <= MEM_RESPOND;
            unlock_q     <= 1'b1;
            wb_valid_q   <= 1'b1;
            wb.rd        <= ex_q.rd;
            wb.data      <= ex_q.ctrl.mem_to_reg ? load_data : ex_q.alu_result;
            // Stores write no register
            wb.reg_write <= ex_q.ctrl.reg_write && !ex_q.ctrl.d_cache_op;
          end
          else
          begin
            count <= count - 1'b1;
          end
        end
        // Lock clears at the end of this cycle
        MEM_RESPOND:
        begin
          state <= MEM_IDLE;
        end
        default:
        begin
          state <= MEM_IDLE;
        end
      endcase
    end
  end

  // A pending pulse waits out the stall
  assign unlock   = unlock_q && !stall;
  assign wb_valid = wb_valid_q && !stall;

  // Back-to-back write-backs need a fresh ALU operation behind the first
  a_wb_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_valid ##1 wb_valid |-> $past(active && !ex_q.ctrl.d_cache_access)
  )
  else $error("wb_valid held without a new operation");

  // Only an active memory operation starts an access
  a_idle_exit: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == MEM_IDLE) ##1 (state != MEM_IDLE)
    |-> $past(active && !stall && ex_q.ctrl.d_cache_access)
  )
  else $error("memory FSM left idle without a memory operation");

endmodule

/* source/execution_registers.sv */
`timescale 1ns/1ps

module execution_registers (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                active,
  input  logic                stall,
  input  logic                unlock,
  input  ex_mem_pkg::issue_t  issue,
  input  ex_mem_pkg::word_t   alu_result,
  input  logic                alu_zero,
  output ex_mem_pkg::ex_mem_t ex_q,
  output logic                active_out,
  output logic                locked
);
  import ex_mem_pkg::*;

  // Next contents, built from the issue port and the ALU
  ex_mem_t ex_d;
  // Operation taken this cycle when not stalled
  logic    capture;

  always_comb
  begin
    ex_d.instruction  = issue.instruction;
    ex_d.ext_imm      = issue.ext_imm;
    ex_d.ctrl         = issue.ctrl;
    ex_d.rd           = issue.rd;
    ex_d.alu_result   = alu_result;
    ex_d.alu_zero     = alu_zero;
    // rs2 goes on as store data
    ex_d.second_input = issue.rs2_value;
  end

  // A locked register refuses new work
  assign capture = active && !locked;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ex_q       <= '0;
      active_out <= 1'b0;
      locked     <= 1'b0;
    end
    else if (!stall)
    begin
      if (capture)
      begin
        ex_q       <= ex_d;
        active_out <= 1'b1;
      end
      else
      begin
        // Bubble downstream, contents stay put
        active_out <= 1'b0;
      end

      // Lock for the whole data memory access
      if (capture && issue.ctrl.d_cache_access)
      begin
        locked <= 1'b1;
      end
      // Memory stage signals the end of the access
      else if (unlock)
      begin
        locked <= 1'b0;
      end
    end
    // Stall holds everything
  end

  // Bubbles only while a memory access is outstanding
  a_no_issue_while_locked: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(active_out) |-> !$past(locked)
  )
  else $error("active_out rose while the register was locked");

  // Unlock from the memory stage must match an earlier lock
  a_unlock_needs_lock: assert property (
    @(posedge clk) disable iff (!rst_n)
    unlock |-> locked
  )
  else $error("unlock arrived while the register was unlocked");

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
  input  ex_mem_pkg::ex_ctrl_t ex_ctrl,
  input  ex_mem_pkg::word_t    rs1_value,
  input  ex_mem_pkg::word_t    rs2_value,
  input  ex_mem_pkg::word_t    ext_imm,
  output ex_mem_pkg::word_t    result,
  output logic                 zero
);
  import ex_mem_pkg::*;

  // Second operand after the immediate select
  word_t      operand_b;
  // Shift amount, low five bits only
  logic [4:0] shamt;
  // Signed compare for slt
  logic       less_signed;

  // Register or sign-extended immediate
  assign operand_b = ex_ctrl.alu_src_imm ? ext_imm : rs2_value;

  assign shamt = operand_b[4:0];

  assign less_signed = $signed(rs1_value) < $signed(operand_b);

  always_comb
  begin
    case (ex_ctrl.alu_op)
      // Also forms load and store addresses
      ALU_ADD:
      begin
        result = rs1_value + operand_b;
      end
      ALU_SUB:
      begin
        result = rs1_value - operand_b;
      end
      ALU_AND:
      begin
        result = rs1_value & operand_b;
      end
      ALU_OR:
      begin
        result = rs1_value | operand_b;
      end
      ALU_XOR:
      begin
        result = rs1_value ^ operand_b;
      end
      // Set to one when rs1 is below operand b, two's complement
      ALU_SLT:
      begin
        result = {31'b0, less_signed};
      end
      // Logical shifts, zeros fill in
      ALU_SLL:
      begin
        result = rs1_value << shamt;
      end
      ALU_SRL:
      begin
        result = rs1_value >> shamt;
      end
      default:
      begin
        result = '0;
      end
    endcase
  end

  // Zero flag travels with the result into the execute register
  assign zero = (result == '0);

endmodule

/* source/ex_mem_pkg.sv */
package ex_mem_pkg;

  // Data path word
  typedef logic [31:0] word_t;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  // ALU operations, loads and stores use add for the address
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_SLL = 3'd6,
    ALU_SRL = 3'd7
  } alu_op_t;

  // Memory stage sequencing
  typedef enum logic [1:0] {
    MEM_IDLE    = 2'd0,
    MEM_ACCESS  = 2'd1,
    MEM_RESPOND = 2'd2
  } mem_state_t;

  // Decoded control bits of one operation
  typedef struct packed {
    alu_op_t alu_op;
    // Immediate as second operand
    logic    alu_src_imm;
    logic    mem_to_reg;
    logic    reg_write;
    logic    d_cache_access;
    // 0 load, 1 store
    logic    d_cache_op;
    logic    is_byte_op;
  } ex_ctrl_t;

  // One operation at the issue port
  typedef struct packed {
    word_t    instruction;
    ex_ctrl_t ctrl;
    reg_idx_t rd;
    word_t    rs1_value;
    word_t    rs2_value;
    word_t    ext_imm;
  } issue_t;

  // Execute register contents
  typedef struct packed {
    word_t    instruction;
    word_t    ext_imm;
    ex_ctrl_t ctrl;
    reg_idx_t rd;
    word_t    alu_result;
    logic     alu_zero;
    // rs2 value, store data
    word_t    second_input;
  } ex_mem_t;

  // Write-back result
  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
    logic     reg_write;
  } wb_t;

endpackage
